/* ppu_cfg.svh */
`ifndef PPU_CFG_SVH
`define PPU_CFG_SVH

// Line and frame geometry, in dots and lines
`define PPU_LINE_CYCLES   456
`define PPU_FRAME_LINES   154
`define PPU_VISIBLE_LINES 144
`define PPU_OAM_CYCLES    80
`define PPU_LINE_PIXELS   160

// APB register offsets
`define PPU_REG_LCDC 4'h0
`define PPU_REG_STAT 4'h1
`define PPU_REG_SCY  4'h2
`define PPU_REG_SCX  4'h3
`define PPU_REG_LY   4'h4
`define PPU_REG_LYC  4'h5
// Offset 6 is the DMA slot on the real part, left unmapped here
`define PPU_REG_BGP  4'h7

`endif

/* ppu_pkg.sv */
package ppu_pkg;

	// STAT mode field encoding
	typedef enum logic [1:0] {
		mode_hblank = 2'd0,
		mode_vblank = 2'd1,
		mode_oam    = 2'd2,
		mode_xfer   = 2'd3
	} ppu_mode_t;

	// Background fetch sequence, one state per cycle except hold
	typedef enum logic [2:0] {
		idle        = 3'd0,
		tile        = 3'd1,
		row_lo_addr = 3'd2,
		row_lo_data = 3'd3,
		row_hi_addr = 3'd4,
		row_hi_data = 3'd5,
		hold        = 3'd6
	} fetch_state_t;

endpackage

/* ppu_regs.sv */
`include "ppu_cfg.svh"

module ppu_regs (
	input  logic               clk,
	input  logic               reset,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  logic [3:0]         paddr,
	input  logic [7:0]         pwdata,
	output logic [7:0]         prdata,
	input  ppu_pkg::ppu_mode_t mode,
	input  logic [7:0]         ly,
	input  logic               lyc_eq,
	output logic               ppu_ena,
	output logic               bg_tiles,
	output logic               bg_map,
	output logic               bg_ena,
	output logic [7:0]         scx,
	output logic [7:0]         scy,
	output logic [7:0]         lyc,
	output logic [7:0]         bgp,
	output logic               sel_lyc,
	output logic               sel_mode2,
	output logic               sel_mode1,
	output logic               sel_mode0,
	output logic               irq_stat
);
	import ppu_pkg::*;

	logic       win_map;  // LCDC bits 6, 5, 2 and 1 are kept for readback only
	logic       win_ena;
	logic       obj_size;
	logic       obj_ena;
	logic       wr_en;
	logic [7:0] rd_data;
	logic       stat_cond;
	logic       stat_q;

	assign wr_en = psel && penable && pwrite;  // Access phase

	always_ff @(posedge clk) begin
		if (reset) begin
			{ppu_ena, win_map, win_ena, bg_tiles} <= '0;
			{bg_map, obj_size, obj_ena, bg_ena} <= '0;
			{sel_lyc, sel_mode2, sel_mode1, sel_mode0} <= '0;
			scy <= '0;
			scx <= '0;
			lyc <= '0;
			bgp <= '0;
		end else if (wr_en) begin
			case (paddr)
				`PPU_REG_LCDC: {ppu_ena, win_map, win_ena, bg_tiles,
						bg_map, obj_size, obj_ena, bg_ena} <= pwdata;
				`PPU_REG_STAT: {sel_lyc, sel_mode2, sel_mode1, sel_mode0} <= pwdata[6:3];
				`PPU_REG_SCY:  scy <= pwdata;
				`PPU_REG_SCX:  scx <= pwdata;
				`PPU_REG_LYC:  lyc <= pwdata;
				`PPU_REG_BGP:  bgp <= pwdata;
				default: ;  // LY is read only
			endcase
		end
	end

	always_comb begin
		case (paddr)
			`PPU_REG_LCDC: rd_data = {ppu_ena, win_map, win_ena, bg_tiles,
						bg_map, obj_size, obj_ena, bg_ena};
			`PPU_REG_STAT: rd_data = {1'b1, sel_lyc, sel_mode2, sel_mode1, sel_mode0,
						lyc_eq, mode};
			`PPU_REG_SCY:  rd_data = scy;
			`PPU_REG_SCX:  rd_data = scx;
			`PPU_REG_LY:   rd_data = ly;
			`PPU_REG_LYC:  rd_data = lyc;
			`PPU_REG_BGP:  rd_data = bgp;
			default:       rd_data = 8'hff;
		endcase
	end

	// Captured in the setup phase, held through the access phase
	always_ff @(posedge clk) begin
		if (reset)
			prdata <= '0;
		else if (psel && !penable)
			prdata <= rd_data;
	end

	// Vblank also raises the mode 2 source, as on the real part
	assign stat_cond = (lyc_eq && sel_lyc) ||
			(mode == mode_hblank && sel_mode0) ||
			(mode == mode_vblank && (sel_mode1 || sel_mode2)) ||
			(mode == mode_oam && sel_mode2);

	always_ff @(posedge clk) begin
		if (reset) begin
			stat_q   <= 1'b0;
			irq_stat <= 1'b0;
		end else begin
			stat_q   <= stat_cond;
			irq_stat <= stat_cond && !stat_q;  // Rising edge only
		end
	end

	a_write_needs_psel: assert property (@(posedge clk) disable iff (reset)
		(penable && pwrite) |-> psel);

endmodule

/* ppu_line_timer.sv */
`include "ppu_cfg.svh"

module ppu_line_timer (
	input  logic               clk,
	input  logic               reset,
	input  logic               ppu_ena,
	input  logic [7:0]         lyc,
	input  logic               line_done,
	output ppu_pkg::ppu_mode_t mode,
	output logic [7:0]         ly,
	output logic               lyc_eq,
	output logic               line_start,
	output logic               hsync,
	output logic               vsync,
	output logic               irq_vblank
);
	import ppu_pkg::*;

	logic [8:0] lx;         // Dot within the line
	logic       xfer_done;  // Pixel transfer finished on this line

	always_ff @(posedge clk) begin
		if (reset || !ppu_ena) begin
			lx        <= '0;
			ly        <= '0;
			xfer_done <= 1'b0;
		end else if (lx == 9'(`PPU_LINE_CYCLES - 1)) begin
			lx        <= '0;
			ly        <= (ly == 8'(`PPU_FRAME_LINES - 1)) ? 8'd0 : ly + 8'd1;
			xfer_done <= 1'b0;
		end else begin
			lx <= lx + 9'd1;
			if (line_done)
				xfer_done <= 1'b1;
		end
	end

	always_comb begin
		if (!ppu_ena)
			mode = mode_hblank;
		else if (ly >= 8'(`PPU_VISIBLE_LINES))
			mode = mode_vblank;
		else if (lx < 9'(`PPU_OAM_CYCLES))
			mode = mode_oam;
		else if (!xfer_done)
			mode = mode_xfer;
		else
			mode = mode_hblank;
	end

	assign line_start = (mode == mode_xfer) && (lx == 9'(`PPU_OAM_CYCLES));
	assign lyc_eq     = ppu_ena && (ly == lyc);
	assign hsync      = ppu_ena && (lx == 9'd0);
	assign vsync      = hsync && (ly == 8'd0);
	assign irq_vblank = hsync && (ly == 8'(`PPU_VISIBLE_LINES));

	// Pixel transfer must finish before the last dot of the line
	a_xfer_ends_in_line: assert property (@(posedge clk) disable iff (reset)
		(mode == mode_xfer) |-> (lx != 9'(`PPU_LINE_CYCLES - 1)));

endmodule

/* ppu_fetcher.sv */
module ppu_fetcher (
	input  logic               clk,
	input  logic               reset,
	input  ppu_pkg::ppu_mode_t mode,
	input  logic               line_start,
	input  logic [7:0]         ly,
	input  logic [7:0]         scx,
	input  logic [7:0]         scy,
	input  logic               bg_map,
	input  logic               bg_tiles,
	input  logic               room,
	output logic               push,
	output logic [7:0]         row_lo,
	output logic [7:0]         row_hi,
	output logic               vram_read,
	output logic [15:0]        vram_adr,
	input  logic [7:0]         vram_data
);
	import ppu_pkg::*;

	fetch_state_t state;
	logic [7:0]   line;      // Background line after vertical scroll
	logic [4:0]   map_row;
	logic [4:0]   map_col;   // Wraps at 32 tiles
	logic [2:0]   fine_y;
	logic [7:0]   tile_num;
	logic [7:0]   tile_idx;

	assign line = scy + ly;

	// The tile number arrives in row_lo_addr and is used straight away
	assign tile_idx = (state == row_lo_addr) ? vram_data : tile_num;
	assign push     = (state == hold) && room;

	always_comb begin
		vram_read = 1'b0;
		// Signed index from 0x9000 unless bg_tiles selects 0x8000
		vram_adr  = {3'b100, !bg_tiles && !tile_idx[7], tile_idx, fine_y, 1'b0};
		case (state)
			tile: begin
				vram_read = 1'b1;
				vram_adr  = {5'b10011, bg_map, map_row, map_col};
			end
			row_lo_addr: vram_read = 1'b1;
			row_hi_addr: begin
				vram_read   = 1'b1;
				vram_adr[0] = 1'b1;  // High bitplane
			end
			default: ;
		endcase
		if (mode != mode_xfer)
			vram_read = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (reset || mode != mode_xfer) begin
			state <= idle;
		end else begin
			case (state)
				idle:        state <= tile;
				tile:        state <= row_lo_addr;
				row_lo_addr: state <= row_lo_data;
				row_lo_data: state <= row_hi_addr;
				row_hi_addr: state <= row_hi_data;
				row_hi_data: state <= hold;
				hold:        if (room) state <= tile;
				default:     state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (line_start) begin
			map_row <= line[7:3];
			map_col <= scx[7:3];
			fine_y  <= line[2:0];
		end else if (state == tile) begin
			map_col <= map_col + 5'd1;
		end
		if (state == row_lo_addr)
			tile_num <= vram_data;
		if (state == row_lo_data)
			row_lo <= vram_data;
		if (state == row_hi_data)
			row_hi <= vram_data;
	end

	// A new line must not reload the map address in the middle of a fetch
	a_start_from_idle: assert property (@(posedge clk) disable iff (reset)
		line_start |-> (state == idle));

endmodule

/* ppu_pixel_fifo.sv */
`include "ppu_cfg.svh"

module ppu_pixel_fifo (
	input  logic               clk,
	input  logic               reset,
	input  ppu_pkg::ppu_mode_t mode,
	input  logic               line_start,
	input  logic               push,
	input  logic [7:0]         row_lo,
	input  logic [7:0]         row_hi,
	input  logic [7:0]         scx,
	input  logic [7:0]         bgp,
	input  logic               bg_ena,
	output logic               room,
	output logic               px_valid,
	output logic [1:0]         px,
	output logic               line_done
);
	import ppu_pkg::*;

	logic [15:0] plane_lo;   // Bit 15 is the next pixel out
	logic [15:0] plane_hi;
	logic [4:0]  fill;
	logic [2:0]  drop_cnt;   // Pixels discarded for fine X scroll
	logic [7:0]  px_cnt;
	logic        shift;
	logic        emit;
	logic [1:0]  color_idx;
	logic [15:0] lo_next;
	logic [15:0] hi_next;
	logic [4:0]  fill_next;

	assign room      = fill <= 5'd8;
	assign shift     = (mode == mode_xfer) && (fill != 5'd0) &&
			(px_cnt != 8'(`PPU_LINE_PIXELS));
	assign emit      = shift && (drop_cnt == scx[2:0]);
	assign line_done = (mode == mode_xfer) && (px_cnt == 8'(`PPU_LINE_PIXELS));
	assign color_idx = {plane_hi[15], plane_lo[15]};

	always_comb begin
		lo_next   = plane_lo;
		hi_next   = plane_hi;
		fill_next = fill;
		if (shift) begin
			lo_next   = {plane_lo[14:0], 1'b0};
			hi_next   = {plane_hi[14:0], 1'b0};
			fill_next = fill - 5'd1;
		end
		// New row lands right behind the pixels still queued
		if (push) begin
			lo_next   = lo_next | ({row_lo, 8'h00} >> fill_next);
			hi_next   = hi_next | ({row_hi, 8'h00} >> fill_next);
			fill_next = fill_next + 5'd8;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || mode != mode_xfer || line_start) begin
			plane_lo <= '0;
			plane_hi <= '0;
			fill     <= '0;
			drop_cnt <= '0;
			px_cnt   <= '0;
		end else begin
			plane_lo <= lo_next;
			plane_hi <= hi_next;
			fill     <= fill_next;
			if (shift && !emit)
				drop_cnt <= drop_cnt + 3'd1;
			if (emit)
				px_cnt <= px_cnt + 8'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			px_valid <= 1'b0;
		else
			px_valid <= emit;
		if (emit)
			px <= bg_ena ? bgp[{color_idx, 1'b0} +: 2] : bgp[1:0];  // Palette lookup
	end

	a_fill_bound: assert property (@(posedge clk) disable iff (reset) fill <= 5'd16);

endmodule

/* ppu_top.sv */
module ppu_top (
	input  logic        clk,
	input  logic        reset,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [3:0]  paddr,
	input  logic [7:0]  pwdata,
	output logic [7:0]  prdata,
	output logic        vram_read,
	output logic [15:0] vram_adr,
	input  logic [7:0]  vram_data,
	output logic        irq_vblank,
	output logic        irq_stat,
	output logic        hsync,
	output logic        vsync,
	output logic        px_valid,
	output logic [1:0]  px
);
	import ppu_pkg::*;

	ppu_mode_t  mode;
	logic [7:0] ly;
	logic       lyc_eq;
	logic       ppu_ena;
	logic       bg_tiles;
	logic       bg_map;
	logic       bg_ena;
	logic [7:0] scx;
	logic [7:0] scy;
	logic [7:0] lyc;
	logic [7:0] bgp;
	logic       line_start;
	logic       line_done;
	logic       room;
	logic       push;
	logic [7:0] row_lo;
	logic [7:0] row_hi;

	// STAT selects are consumed inside the register block
	ppu_regs regs_i (
		.clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
		.mode, .ly, .lyc_eq, .ppu_ena, .bg_tiles, .bg_map, .bg_ena,
		.scx, .scy, .lyc, .bgp,
		.sel_lyc(), .sel_mode2(), .sel_mode1(), .sel_mode0(), .irq_stat
	);

	ppu_line_timer timer_i (
		.clk, .reset, .ppu_ena, .lyc, .line_done,
		.mode, .ly, .lyc_eq, .line_start, .hsync, .vsync, .irq_vblank
	);

	ppu_fetcher fetcher_i (
		.clk, .reset, .mode, .line_start, .ly, .scx, .scy, .bg_map, .bg_tiles,
		.room, .push, .row_lo, .row_hi, .vram_read, .vram_adr, .vram_data
	);

	ppu_pixel_fifo fifo_i (
		.clk, .reset, .mode, .line_start, .push, .row_lo, .row_hi,
		.scx, .bgp, .bg_ena, .room, .px_valid, .px, .line_done
	);

endmodule

/* tb_ppu.sv */
`include "ppu_cfg.svh"

module tb_ppu;
	logic        clk;
	logic        reset;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [3:0]  paddr;
	logic [7:0]  pwdata;
	logic [7:0]  prdata;
	logic        vram_read;
	logic [15:0] vram_adr;
	logic [7:0]  vram_data;
	logic        irq_vblank;
	logic        irq_stat;
	logic        hsync;
	logic        vsync;
	logic        px_valid;
	logic [1:0]  px;

	logic [7:0]  vram_mem [0:8191];  // 0x8000 to 0x9FFF
	logic        rd_pend;
	logic [15:0] rd_adr;

	// Display setup as last written over APB
	logic [7:0]  cfg_scx;
	logic [7:0]  cfg_scy;
	logic [7:0]  cfg_bgp;
	logic        cfg_map;
	logic        cfg_tiles;
	logic        cfg_bgena;

	logic        mon_on;      // Line monitor active
	logic        stat_check;  // Expect one STAT interrupt per frame
	int          cycle;
	int          last_hs;
	int          cur_line;
	int          line_px;
	int          vblank_cnt;
	int          stat_cnt;

	ppu_top dut_i (
		.clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
		.vram_read, .vram_adr, .vram_data,
		.irq_vblank, .irq_stat, .hsync, .vsync, .px_valid, .px
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check_value(input int actual, input int expected, input string what);
		if (actual != expected) begin
			$display("MISMATCH at time %0t: %s, got 0x%0h, expected 0x%0h",
				$time, what, actual, expected);
			$display("ERRORS FOUND");
			$fatal(1, "value check failed");
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("Timeout at time %0t: %s did not happen in time", $time, what);
		$display("ERRORS FOUND");
		$fatal(1, "wait timed out");
	endtask

	task automatic reg_write(input logic [3:0] addr, input logic [7:0] data);
		@(negedge clk);
		psel    = 1'b1;  // Setup phase
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(negedge clk);
		penable = 1'b1;
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic reg_read(input logic [3:0] addr, output logic [7:0] data);
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		@(negedge clk);
		penable = 1'b1;
		data    = prdata;  // Valid through the access phase
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic readback_reg(input logic [3:0] addr);
		logic [7:0] val;
		logic [7:0] rd;
		val = 8'($urandom);
		reg_write(addr, val);
		reg_read(addr, rd);
		check_value(32'(rd), 32'(val), $sformatf("readback at offset %0d", addr));
	endtask

	task automatic count_vsyncs(input int n);
		int seen;
		int waited;
		seen   = 0;
		waited = 0;
		while (seen < n) begin
			@(negedge clk);
			if (vsync)
				seen++;
			waited++;
			if (waited > n * `PPU_LINE_CYCLES * `PPU_FRAME_LINES + 1000)
				fail_timeout("vsync pulse");
		end
	endtask

	task automatic wait_irq_stat();
		int waited;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
			if (waited > `PPU_LINE_CYCLES * `PPU_FRAME_LINES + 1000)
				fail_timeout("STAT interrupt");
		end while (!irq_stat);
	endtask

	function automatic logic [7:0] lcdc_value(input logic on);
		return {on, 2'b00, cfg_tiles, cfg_map, 2'b00, cfg_bgena};
	endfunction

	// Display off, new random scroll and palette, display on again
	task automatic configure_display(input logic bg_on);
		mon_on = 1'b0;
		reg_write(`PPU_REG_LCDC, 8'h00);
		cfg_scx   = 8'($urandom);
		cfg_scy   = 8'($urandom);
		cfg_bgp   = 8'($urandom);
		cfg_map   = 1'($urandom);
		cfg_tiles = 1'($urandom);
		cfg_bgena = bg_on;
		reg_write(`PPU_REG_SCX, cfg_scx);
		reg_write(`PPU_REG_SCY, cfg_scy);
		reg_write(`PPU_REG_BGP, cfg_bgp);
		mon_on = 1'b1;
		reg_write(`PPU_REG_LCDC, lcdc_value(1'b1));
	endtask

	// Background pixel x of screen line y
	function automatic logic [1:0] model_pixel(input int y, input int x);
		logic [7:0]  bx;
		logic [7:0]  by;
		logic [7:0]  tile_no;
		logic [7:0]  lo;
		logic [7:0]  hi;
		logic [15:0] map_adr;
		logic [15:0] row_adr;
		logic [1:0]  idx;
		logic [7:0]  shade;
		bx      = 8'(x + int'(cfg_scx));
		by      = 8'(y + int'(cfg_scy));
		map_adr = (cfg_map ? 16'h9c00 : 16'h9800) + {6'd0, by[7:3], 5'd0} + {11'd0, bx[7:3]};
		tile_no = vram_mem[map_adr[12:0]];
		if (cfg_tiles)
			row_adr = 16'h8000 + {4'd0, tile_no, 4'd0};
		else
			row_adr = 16'h9000 + {{4{tile_no[7]}}, tile_no, 4'd0};  // Signed tile index
		row_adr = row_adr + {12'd0, by[2:0], 1'b0};
		lo      = vram_mem[row_adr[12:0]];
		hi      = vram_mem[row_adr[12:0] + 13'd1];
		idx     = {hi[3'd7 - bx[2:0]], lo[3'd7 - bx[2:0]]};
		shade   = cfg_bgena ? (cfg_bgp >> {idx, 1'b0}) : cfg_bgp;
		return shade[1:0];
	endfunction

	// Video RAM answers one cycle after the read
	always @(posedge clk) begin
		rd_pend <= vram_read;
		rd_adr  <= vram_adr;
	end

	always @(negedge clk) begin
		if (rd_pend)
			vram_data <= vram_mem[rd_adr[12:0]];
	end

	// Line, frame and pixel monitor
	always @(negedge clk) begin
		cycle++;
		if (!mon_on) begin
			last_hs    = -1;
			cur_line   = -1;
			line_px    = 0;
			vblank_cnt = 0;
			stat_cnt   = 0;
		end else begin
			if (hsync) begin
				if (last_hs >= 0)
					check_value(cycle - last_hs, `PPU_LINE_CYCLES, "cycles between hsyncs");
				last_hs = cycle;
				if (cur_line >= 0) begin
					check_value(line_px, (cur_line < `PPU_VISIBLE_LINES) ? `PPU_LINE_PIXELS : 0,
						$sformatf("pixel count of line %0d", cur_line));
					if (vsync) begin
						check_value(cur_line, `PPU_FRAME_LINES - 1, "hsyncs per frame");
						check_value(vblank_cnt, 1, "vblank interrupts per frame");
						if (stat_check)
							check_value(stat_cnt, 1, "STAT interrupts per frame");
					end
				end
				if (vsync) begin
					cur_line   = 0;
					vblank_cnt = 0;
					stat_cnt   = 0;
				end else if (cur_line >= 0) begin
					cur_line++;
				end
				line_px = 0;
			end
			if (irq_vblank) begin
				check_value(cur_line, `PPU_VISIBLE_LINES, "line of vblank interrupt");
				vblank_cnt++;
			end
			if (irq_stat)
				stat_cnt++;
			if (px_valid && cur_line >= 0) begin
				check_value(32'(px), 32'(model_pixel(cur_line, line_px)),
					$sformatf("pixel %0d of line %0d", line_px, cur_line));
				line_px++;
			end
		end
	end

	initial begin
		logic [7:0] rd;
		logic [7:0] lyc_val;
		void'($urandom(90));
		reset      = 1'b1;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = 4'h0;
		pwdata     = 8'h00;
		vram_data  = 8'h00;
		mon_on     = 1'b0;
		stat_check = 1'b0;
		cycle      = 0;
		cfg_scx    = 8'h00;
		cfg_scy    = 8'h00;
		cfg_bgp    = 8'h00;
		cfg_map    = 1'b0;
		cfg_tiles  = 1'b0;
		cfg_bgena  = 1'b0;
		for (int i = 0; i < 8192; i++)
			vram_mem[i] = 8'($urandom);
		repeat (8) @(negedge clk);
		reset = 1'b0;

		for (int i = 0; i < 16; i++) begin
			reg_read(4'(i), rd);
			check_value(32'(rd), (i == 1) ? 32'h80 : (i == 6 || i > 7) ? 32'hff : 32'h00,
				$sformatf("reset value at offset %0d", i));
		end
		readback_reg(`PPU_REG_SCY);
		readback_reg(`PPU_REG_SCX);
		readback_reg(`PPU_REG_LYC);
		readback_reg(`PPU_REG_BGP);
		reg_write(`PPU_REG_LY, 8'h5a);  // Read only
		reg_read(`PPU_REG_LY, rd);
		check_value(32'(rd), 0, "LY after write");

		configure_display(1'b1);
		count_vsyncs(3);
		configure_display(1'b0);
		count_vsyncs(2);

		// LY coincidence interrupt
		lyc_val = 8'($urandom_range(0, `PPU_VISIBLE_LINES - 1));
		mon_on  = 1'b0;
		reg_write(`PPU_REG_LCDC, 8'h00);
		reg_write(`PPU_REG_LYC, lyc_val);
		reg_write(`PPU_REG_STAT, 8'h40);
		stat_check = 1'b1;
		mon_on     = 1'b1;
		reg_write(`PPU_REG_LCDC, lcdc_value(1'b1));
		wait_irq_stat();
		reg_read(`PPU_REG_STAT, rd);
		check_value(32'(rd[2]), 1, "STAT coincidence bit at interrupt");
		reg_read(`PPU_REG_LY, rd);
		check_value(32'(rd), 32'(lyc_val), "LY at STAT interrupt");
		count_vsyncs(3);

		mon_on     = 1'b0;
		stat_check = 1'b0;
		reg_write(`PPU_REG_LCDC, lcdc_value(1'b0));
		for (int i = 0; i < 1000; i++) begin
			@(negedge clk);
			check_value(32'(hsync), 0, "hsync with display off");
			check_value(32'(px_valid), 0, "px_valid with display off");
			check_value(32'(vram_read), 0, "vram_read with display off");
		end
		reg_read(`PPU_REG_LY, rd);
		check_value(32'(rd), 0, "LY with display off");

		$display("NO ERRORS");
		$finish;
	end

endmodule

/* src.f */
+incdir+.
ppu_pkg.sv
ppu_regs.sv
ppu_line_timer.sv
ppu_fetcher.sv
ppu_pixel_fifo.sv
ppu_top.sv
tb_ppu.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the PPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_ppu -o tb_ppu_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Build failed"
	exit 1
fi

./obj_dir/tb_ppu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^NO ERRORS$" sim.log; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed"
exit 1
